/* list.f */
+incdir+.
fsync_pkg.sv
fsync_rf_if.sv
fsync_fifo.sv
fsync_sync_rf.sv
fsync_port_ctrl.sv
fsync_cc.sv
tb_fsync_cc.sv

/* run.sh */
#!/bin/sh
# Builds the node testbench with Verilator and runs it.
# The exit status is the simulator's exit status.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_fsync_cc \
  -f list.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/Vtb_fsync_cc
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
fi
exit "$status"

/* tb_fsync_cc.sv */
// Testbench of the synchronization node: drives both RX ports and TX lookups against a table model.
`timescale 1ns/100ps
`default_nettype none

`include "fsync_defs.svh"

module tb_fsync_cc;
  import fsync_pkg::*;

  localparam int N_RX    = `FSYNC_N_RX;
  localparam int N_REGS  = `FSYNC_N_REGS;
  localparam int DEPTH   = `FSYNC_FIFO_DEPTH;
  localparam int AGGR_W  = `FSYNC_AGGR_W;
  localparam int UP_W    = AGGR_W - 1;
  localparam int W       = $bits(fsync_rsp_t);  // Response and upward request are both 7 bits.
  localparam int TIMEOUT = 20;                  // Cycles allowed for any wait.

  logic           clk_i;
  logic           rst_ni;
  fsync_req_in_t  req_i            [N_RX];
  logic           check_rf_i       [N_RX];
  logic           local_i          [N_RX];
  logic           root_i           [N_RX];
  logic           check_br_i;
  fsync_id_t      rsp_id_i;
  logic           en_br_o;
  logic           ws_br_o;
  logic           local_empty_o    [N_RX];
  fsync_rsp_t     local_rsp_o      [N_RX];
  logic           local_pop_i      [N_RX];
  logic           remote_empty_o   [N_RX];
  fsync_req_out_t remote_req_o     [N_RX];
  logic           remote_pop_i     [N_RX];
  logic           detected_error_o [N_RX+1];

  logic [31:0]    rng_q;
  logic           model_local  [N_REGS];
  logic           model_remote [N_REGS];
  fsync_sd_t      model_sd     [N_REGS];
  logic [W-1:0]   exp_q        [2*N_RX][$];  // FIFOs 0 and 1 local, 2 and 3 remote.
  logic           err_allowed  [N_RX+1];     // Error pulse expected on that bit.

  fsync_cc UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input string exp, input string act);
    report_failure($sformatf("mismatch %s: expected %s, actual %s", name, exp, act));
  endtask

  for (genvar i = 0; i <= N_RX; i++) begin : gen_err_chk
    a_err_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
      detected_error_o[i] |-> err_allowed[i])
      else report_failure($sformatf("detected_error_o[%0d] raised without a cause", i));
  end

  a_br_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !check_br_i |-> !en_br_o && !ws_br_o)
    else report_failure("back-route output active without a TX lookup");

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_q;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_q = x;
    return x;
  endfunction

  function automatic fsync_id_t rand_id();
    return fsync_id_t'(next_rand() % N_REGS);  // Always a valid table entry.
  endfunction

  function automatic fsync_req_in_t make_req(input fsync_id_t id);
    fsync_req_in_t req;
    req.sync = 1'b1;
    req.aggr = AGGR_W'(next_rand());
    req.id   = id;
    return req;
  endfunction

  // Level is the position of the most significant set aggregate bit.
  function automatic fsync_lvl_t top_bit(input logic [AGGR_W-1:0] aggr);
    fsync_lvl_t l;
    logic       found;
    l     = '0;
    found = 1'b0;
    for (int j = AGGR_W - 1; j >= 0; j--) begin
      if (aggr[j] && !found) begin
        l     = fsync_lvl_t'(j);
        found = 1'b1;
      end
    end
    return l;
  endfunction

  function automatic logic fifo_empty(input int f);
    if (f < N_RX) return local_empty_o[f];
    else return remote_empty_o[f - N_RX];
  endfunction

  function automatic logic [W-1:0] fifo_head(input int f);
    if (f < N_RX) return local_rsp_o[f];
    else return remote_req_o[f - N_RX];
  endfunction

  task automatic set_pop(input int f, input logic v);
    if (f < N_RX) local_pop_i[f] = v;
    else remote_pop_i[f - N_RX] = v;
  endtask

  // A push into a full FIFO is lost and flags that port.
  task automatic expect_push(input int f, input logic [W-1:0] data);
    if (exp_q[f].size() >= DEPTH) err_allowed[f % N_RX] = 1'b1;
    else exp_q[f].push_back(data);
  endtask

  task automatic model_rx(input int p, input fsync_req_in_t req, input logic loc,
                          input logic root);
    fsync_sd_t      dir;
    fsync_rsp_t     rsp;
    fsync_req_out_t up;
    logic           in_range;
    in_range  = int'(req.id) < N_REGS;
    dir.en    = (p == 0);  // Port 0 faces east-north.
    dir.ws    = (p == 1);
    rsp.wake  = 1'b1;
    rsp.lvl   = top_bit(req.aggr);
    rsp.id    = req.id;
    rsp.error = !in_range;
    up.sync   = req.sync;
    up.aggr   = UP_W'(req.aggr >> 1);
    up.id     = req.id;
    if (loc && !in_range) begin
      expect_push(p, rsp);
    end else if (loc && root) begin
      if (model_local[req.id]) expect_push(p, rsp);  // Second arrival wakes.
      model_local[req.id] = !model_local[req.id];
    end else if (loc) begin
      if (model_remote[req.id]) expect_push(N_RX + p, up);
      model_remote[req.id] = !model_remote[req.id];
      model_sd[req.id]     = model_sd[req.id] | dir;
    end else if (in_range) begin
      model_sd[req.id] = model_sd[req.id] | dir;  // Forwarded.
    end
  endtask

  task automatic drive_rx(input int p, input fsync_req_in_t req, input logic loc,
                          input logic root);
    req_i[p]      = req;
    check_rf_i[p] = 1'b1;
    local_i[p]    = loc;
    root_i[p]     = root;
    model_rx(p, req, loc, root);
  endtask

  task automatic release_rx();
    for (int i = 0; i < N_RX; i++) begin
      check_rf_i[i] = 1'b0;
    end
  endtask

  // One-cycle pulse; an overflow shows up in the cycle after the pulse.
  task automatic send_req(input int p, input fsync_req_in_t req, input logic loc,
                          input logic root);
    @(negedge clk_i);
    drive_rx(p, req, loc, root);
    @(negedge clk_i);
    release_rx();
    #5;
    assert (!err_allowed[p] || detected_error_o[p])
      else report_failure($sformatf("no overflow error reported on port %0d", p));
    if (err_allowed[p]) begin
      @(negedge clk_i);
      err_allowed[p] = 1'b0;
    end
  endtask

  task automatic pop_check(input int f, input string name);
    int           cycles;
    logic [W-1:0] exp;
    logic [W-1:0] act;
    cycles = 0;
    @(negedge clk_i);
    while (fifo_empty(f) && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    assert (!fifo_empty(f))
      else report_failure($sformatf("%s: timeout waiting for data in FIFO %0d", name, f));
    assert (exp_q[f].size() != 0)
      else report_failure($sformatf("%s: FIFO %0d holds an unexpected entry", name, f));
    exp = exp_q[f].pop_front();
    act = fifo_head(f);
    assert (act == exp) else report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    set_pop(f, 1'b1);
    @(negedge clk_i);
    set_pop(f, 1'b0);
  endtask

  task automatic check_empties(input string name);
    @(negedge clk_i);
    for (int f = 0; f < 2 * N_RX; f++) begin
      assert (fifo_empty(f) == (exp_q[f].size() == 0))
        else report_mismatch($sformatf("%s FIFO %0d empty", name, f),
                             $sformatf("%0b", exp_q[f].size() == 0),
                             $sformatf("%0b", fifo_empty(f)));
    end
  endtask

  // Lookup result is combinational; the record clears at the next edge.
  task automatic tx_lookup(input fsync_id_t id, input string name);
    logic      in_range;
    fsync_sd_t exp;
    in_range = int'(id) < N_REGS;
    exp      = '0;
    if (in_range) exp = model_sd[id];
    @(negedge clk_i);
    check_br_i        = 1'b1;
    rsp_id_i          = id;
    err_allowed[N_RX] = !in_range;
    #5;
    assert ({ws_br_o, en_br_o} == exp)
      else report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", {ws_br_o, en_br_o}));
    assert (detected_error_o[N_RX] == !in_range)
      else report_mismatch({name, " error"}, $sformatf("%b", !in_range),
                           $sformatf("%b", detected_error_o[N_RX]));
    if (in_range) model_sd[id] = '0;
    @(negedge clk_i);
    check_br_i        = 1'b0;
    err_allowed[N_RX] = 1'b0;
  endtask

  initial begin
    fsync_id_t id;
    rng_q      = 32'd35;
    rst_ni     = 1'b0;
    check_br_i = 1'b0;
    rsp_id_i   = '0;
    for (int i = 0; i < N_RX; i++) begin
      req_i[i]        = '0;
      check_rf_i[i]   = 1'b0;
      local_i[i]      = 1'b0;
      root_i[i]       = 1'b0;
      local_pop_i[i]  = 1'b0;
      remote_pop_i[i] = 1'b0;
    end
    for (int i = 0; i <= N_RX; i++) begin
      err_allowed[i] = 1'b0;
    end
    for (int i = 0; i < N_REGS; i++) begin
      model_local[i]  = 1'b0;
      model_remote[i] = 1'b0;
      model_sd[i]     = '0;
    end
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_empties("reset");

    // Root barrier on port 0.
    id = rand_id();
    send_req(0, make_req(id), 1'b1, 1'b1);
    check_empties("root first arrival");
    send_req(0, make_req(id), 1'b1, 1'b1);
    pop_check(0, "root barrier");
    check_empties("root barrier");

    // Aggregation over both ports, then the back-route record.
    id = rand_id();
    send_req(0, make_req(id), 1'b1, 1'b0);
    send_req(1, make_req(id), 1'b1, 1'b0);
    pop_check(N_RX + 1, "aggregation");
    check_empties("aggregation");
    tx_lookup(id, "aggregation lookup");
    tx_lookup(id, "aggregation second lookup");

    // Same id on both ports in one cycle completes on port 1.
    id = rand_id();
    @(negedge clk_i);
    drive_rx(0, make_req(id), 1'b1, 1'b1);
    drive_rx(1, make_req(id), 1'b1, 1'b1);
    @(negedge clk_i);
    release_rx();
    assert (local_empty_o[0] && local_empty_o[1])
      else report_failure("same-cycle response appeared one edge after the pulse");
    @(negedge clk_i);
    assert (local_empty_o[0] && !local_empty_o[1])
      else report_failure("same-cycle response not on port 1 two edges after the pulse");
    pop_check(1, "same-cycle bypass");
    check_empties("same-cycle bypass");

    // Ids 6 and 7 lie beyond the tables.
    id = fsync_id_t'(N_REGS + (next_rand() & 32'd1));
    send_req(1, make_req(id), 1'b1, 1'b0);
    pop_check(1, "out-of-range response");
    check_empties("out-of-range");
    tx_lookup(id, "out-of-range lookup");

    // Third completion overflows the local FIFO of port 0.
    for (int n = 0; n < 3; n++) begin
      id = rand_id();
      send_req(0, make_req(id), 1'b1, 1'b1);
      send_req(0, make_req(id), 1'b1, 1'b1);
    end
    pop_check(0, "back-pressure first");
    pop_check(0, "back-pressure second");
    check_empties("back-pressure");
    @(negedge clk_i);
    err_allowed[0] = 1'b1;
    local_pop_i[0] = 1'b1;
    #5;
    assert (detected_error_o[0]) else report_failure("pop on an empty FIFO not reported");
    @(negedge clk_i);
    local_pop_i[0] = 1'b0;
    err_allowed[0] = 1'b0;

    // Forwarded request only leaves a direction behind.
    id = rand_id();
    send_req(1, make_req(id), 1'b0, 1'b0);
    check_empties("forwarded");
    tx_lookup(id, "forwarded lookup");

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* fsync_cc.sv */
// Top of the horizontal synchronization node: two RX controllers, shared tables and four FIFOs.
`timescale 1ns/100ps
`default_nettype none

`include "fsync_defs.svh"

module fsync_cc (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  fsync_pkg::fsync_req_in_t  req_i            [`FSYNC_N_RX],
  input  logic                      check_rf_i       [`FSYNC_N_RX],
  input  logic                      local_i          [`FSYNC_N_RX],
  input  logic                      root_i           [`FSYNC_N_RX],

  input  logic                      check_br_i,
  input  fsync_pkg::fsync_id_t      rsp_id_i,
  output logic                      en_br_o,
  output logic                      ws_br_o,

  output logic                      local_empty_o    [`FSYNC_N_RX],
  output fsync_pkg::fsync_rsp_t     local_rsp_o      [`FSYNC_N_RX],
  input  logic                      local_pop_i      [`FSYNC_N_RX],

  output logic                      remote_empty_o   [`FSYNC_N_RX],
  output fsync_pkg::fsync_req_out_t remote_req_o     [`FSYNC_N_RX],
  input  logic                      remote_pop_i     [`FSYNC_N_RX],

  output logic                      detected_error_o [`FSYNC_N_RX+1]
);
  import fsync_pkg::*;

  logic           push_local  [`FSYNC_N_RX];
  logic           push_remote [`FSYNC_N_RX];
  fsync_rsp_t     local_rsp   [`FSYNC_N_RX];
  fsync_req_out_t remote_req  [`FSYNC_N_RX];
  logic           local_err   [`FSYNC_N_RX];
  logic           remote_err  [`FSYNC_N_RX];
  logic           br_err;

  fsync_rf_if rf_if [`FSYNC_N_RX] ();

  fsync_sync_rf i_rf (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .rx0        ( rf_if[0]   ),  // East-north port.
    .rx1        ( rf_if[1]   ),  // West-south port.
    .check_br_i ( check_br_i ),
    .rsp_id_i   ( rsp_id_i   ),
    .en_br_o    ( en_br_o    ),
    .ws_br_o    ( ws_br_o    ),
    .br_err_o   ( br_err     )
  );

  for (genvar i = 0; i < `FSYNC_N_RX; i++) begin : gen_rx
    fsync_port_ctrl #(
      .PORT_IDX ( i )
    ) i_ctrl (
      .clk_i         ( clk_i          ),
      .rst_ni        ( rst_ni         ),
      .req_i         ( req_i[i]       ),
      .check_rf_i    ( check_rf_i[i]  ),
      .local_i       ( local_i[i]     ),
      .root_i        ( root_i[i]      ),
      .rf            ( rf_if[i]       ),
      .push_local_o  ( push_local[i]  ),
      .local_rsp_o   ( local_rsp[i]   ),
      .push_remote_o ( push_remote[i] ),
      .remote_req_o  ( remote_req[i]  )
    );

    fsync_fifo #(
      .DEPTH     ( `FSYNC_FIFO_DEPTH ),
      .payload_t ( fsync_rsp_t       )
    ) i_local_fifo (
      .clk_i   ( clk_i            ),
      .rst_ni  ( rst_ni           ),
      .push_i  ( push_local[i]    ),
      .data_i  ( local_rsp[i]     ),
      .pop_i   ( local_pop_i[i]   ),
      .data_o  ( local_rsp_o[i]   ),
      .empty_o ( local_empty_o[i] ),
      .full_o  (                  ),
      .err_o   ( local_err[i]     )
    );

    fsync_fifo #(
      .DEPTH     ( `FSYNC_FIFO_DEPTH ),
      .payload_t ( fsync_req_out_t   )
    ) i_remote_fifo (
      .clk_i   ( clk_i             ),
      .rst_ni  ( rst_ni            ),
      .push_i  ( push_remote[i]    ),
      .data_i  ( remote_req[i]     ),
      .pop_i   ( remote_pop_i[i]   ),
      .data_o  ( remote_req_o[i]   ),
      .empty_o ( remote_empty_o[i] ),
      .full_o  (                   ),
      .err_o   ( remote_err[i]     )
    );

    assign detected_error_o[i] = local_err[i] | remote_err[i];  // Either FIFO misused.
  end

  assign detected_error_o[`FSYNC_N_RX] = br_err;  // TX lookup out of range.

endmodule

`default_nettype wire

/* fsync_port_ctrl.sv */
// Per-RX-port controller: registers a request, queries the register file and pushes the FIFOs.
`timescale 1ns/100ps
`default_nettype none

`include "fsync_defs.svh"

module fsync_port_ctrl #(
  parameter int unsigned PORT_IDX = 0
)(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  fsync_pkg::fsync_req_in_t  req_i,
  input  logic                      check_rf_i,
  input  logic                      local_i,
  input  logic                      root_i,
  fsync_rf_if.ctrl                  rf,
  output logic                      push_local_o,
  output fsync_pkg::fsync_rsp_t     local_rsp_o,
  output logic                      push_remote_o,
  output fsync_pkg::fsync_req_out_t remote_req_o
);
  import fsync_pkg::*;

  typedef enum logic {
    IDLE,
    CHECK
  } state_e;

  localparam fsync_sd_t DIR = (PORT_IDX == 0) ? SD_EAST_NORTH : SD_WEST_SOUTH;

  state_e        state_q;
  state_e        state_d;
  fsync_req_in_t req_q;
  logic          local_q;
  logic          root_q;
  logic          id_err;
  fsync_lvl_t    lvl;

  // Every pulse is decided in the next cycle, so CHECK simply follows the pulse.
  assign state_d = check_rf_i ? CHECK : IDLE;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (check_rf_i) begin
      req_q   <= req_i;
      local_q <= local_i;
      root_q  <= root_i;
    end
  end

  assign id_err = int'(req_q.id) >= `FSYNC_N_REGS;  // Beyond the table.

  // Level is the highest set aggregate bit.
  always_comb begin
    lvl = '0;
    for (int j = 0; j < `FSYNC_AGGR_W; j++) begin
      if (req_q.aggr[j]) lvl = fsync_lvl_t'(j);
    end
  end

  always_comb begin
    rf.check_local  = 1'b0;
    rf.check_remote = 1'b0;
    rf.set_remote   = 1'b0;
    rf.id           = req_q.id;
    rf.sd           = '0;
    push_local_o    = 1'b0;
    push_remote_o   = 1'b0;
    if (state_q == CHECK) begin
      if (local_q && id_err) begin
        push_local_o = 1'b1;                    // Error response, table untouched.
      end else if (local_q && root_q) begin
        rf.check_local = 1'b1;
        push_local_o   = rf.present_local;      // Second arrival wakes.
      end else if (local_q) begin
        rf.check_remote = 1'b1;
        rf.set_remote   = 1'b1;
        rf.sd           = DIR;
        push_remote_o   = rf.present_remote;    // Second arrival goes up.
      end else if (!id_err) begin
        rf.set_remote = 1'b1;                   // Forwarded, only record direction.
        rf.sd         = DIR;
      end
    end
  end

  assign local_rsp_o = '{wake: 1'b1, lvl: lvl, id: req_q.id, error: id_err};

  assign remote_req_o = '{
    sync: req_q.sync,
    aggr: req_q.aggr[`FSYNC_AGGR_W-1:1],
    id:   req_q.id
  };

  // Presence comes back only for a strobe of this port.
  a_present_on_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!rf.present_local || rf.check_local) && (!rf.present_remote || rf.check_remote))
    else $error("fsync_port_ctrl: presence reported without a check strobe");

endmodule

`default_nettype wire

/* fsync_sync_rf.sv */
// Presence and back-route tables shared by both RX controllers, plus the TX direction lookup.
`timescale 1ns/100ps
`default_nettype none

`include "fsync_defs.svh"

module fsync_sync_rf (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  fsync_rf_if.rf               rx0,
  fsync_rf_if.rf               rx1,
  input  logic                 check_br_i,
  input  fsync_pkg::fsync_id_t rsp_id_i,
  output logic                 en_br_o,
  output logic                 ws_br_o,
  output logic                 br_err_o
);
  import fsync_pkg::*;

  localparam int unsigned N = `FSYNC_N_REGS;

  logic [N-1:0] local_q;
  logic [N-1:0] local_d;
  logic [N-1:0] remote_q;
  logic [N-1:0] remote_d;
  fsync_sd_t    sd_q [N];
  fsync_sd_t    sd_d [N];
  logic         tx_ok;
  fsync_sd_t    tx_sd;

  assign tx_ok = int'(rsp_id_i) < N;

  // Port 0 is applied before port 1, so a same-cycle pair completes on port 1.
  always_comb begin
    local_d  = local_q;
    remote_d = remote_q;
    sd_d     = sd_q;

    rx0.present_local  = 1'b0;
    rx0.present_remote = 1'b0;
    rx1.present_local  = 1'b0;
    rx1.present_remote = 1'b0;

    // TX clear first; a set from the same cycle survives.
    if (check_br_i && tx_ok) sd_d[rsp_id_i] = '0;

    if (rx0.check_local) begin
      rx0.present_local = local_d[rx0.id];
      local_d[rx0.id]   = !local_d[rx0.id];  // Set on first, clear on second.
    end
    if (rx0.check_remote) begin
      rx0.present_remote = remote_d[rx0.id];
      remote_d[rx0.id]   = !remote_d[rx0.id];
    end
    if (rx0.set_remote) sd_d[rx0.id] = sd_d[rx0.id] | rx0.sd;

    if (rx1.check_local) begin
      rx1.present_local = local_d[rx1.id];  // Sees port 0's update.
      local_d[rx1.id]   = !local_d[rx1.id];
    end
    if (rx1.check_remote) begin
      rx1.present_remote = remote_d[rx1.id];
      remote_d[rx1.id]   = !remote_d[rx1.id];
    end
    if (rx1.set_remote) sd_d[rx1.id] = sd_d[rx1.id] | rx1.sd;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      local_q  <= '0;
      remote_q <= '0;
      sd_q     <= '{default: '0};
    end else begin
      local_q  <= local_d;
      remote_q <= remote_d;
      sd_q     <= sd_d;
    end
  end

  // Old record is returned, cleared at the next edge.
  assign tx_sd    = (check_br_i && tx_ok) ? sd_q[rsp_id_i] : '0;
  assign en_br_o  = tx_sd.en;
  assign ws_br_o  = tx_sd.ws;
  assign br_err_o = check_br_i && !tx_ok;  // Lookup of an id beyond the table.

  // Controllers filter bad ids; no strobe may reach the tables with one.
  a_rx0_id_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rx0.check_local || rx0.check_remote || rx0.set_remote) |-> int'(rx0.id) < N)
    else $error("fsync_sync_rf: port 0 strobe with out-of-range id");

  a_rx1_id_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rx1.check_local || rx1.check_remote || rx1.set_remote) |-> int'(rx1.id) < N)
    else $error("fsync_sync_rf: port 1 strobe with out-of-range id");

endmodule

`default_nettype wire

/* fsync_fifo.sv */
// Synchronous FIFO with a type-parameter payload, used for wake responses and upward requests.
`timescale 1ns/100ps
`default_nettype none

module fsync_fifo #(
  parameter int unsigned DEPTH     = 2,
  parameter type         payload_t = logic
)(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o,
  output logic     err_o
);

  localparam int unsigned      PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned      CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST  = PTR_W'(DEPTH - 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push;
  logic             do_pop;

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign do_push = push_i && !full_o;   // Overflowing push is dropped.
  assign do_pop  = pop_i && !empty_o;   // Underflowing pop is ignored.
  assign err_o   = (push_i && full_o) || (pop_i && empty_o);
  assign data_o  = mem[rd_ptr_q];       // Head entry, valid while not empty.

  always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // Occupancy stays within the buffer across any push/pop mix.
  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= CNT_W'(DEPTH))
    else $error("fsync_fifo: occupancy above DEPTH");

endmodule

`default_nettype wire

/* fsync_rf_if.sv */
// Strobe and presence bundle between one RX port controller and the shared register file.
`timescale 1ns/100ps
`default_nettype none

interface fsync_rf_if;
  import fsync_pkg::*;

  logic      check_local;     // Toggle the local presence bit.
  logic      check_remote;    // Toggle the remote presence bit.
  logic      set_remote;      // OR sd into the back-route record.
  fsync_id_t id;              // Entry addressed by all strobes.
  fsync_sd_t sd;              // Arrival direction to record.
  logic      present_local;   // Local bit was already set.
  logic      present_remote;  // Remote bit was already set.

  modport ctrl (
    output check_local,
    output check_remote,
    output set_remote,
    output id,
    output sd,
    input  present_local,
    input  present_remote
  );

  modport rf (
    input  check_local,
    input  check_remote,
    input  set_remote,
    input  id,
    input  sd,
    output present_local,
    output present_remote
  );

endinterface

`default_nettype wire

/* fsync_pkg.sv */
// Request, response and back-route types of the synchronization node, imported by all blocks.
`default_nettype none

`include "fsync_defs.svh"

package fsync_pkg;

  localparam int unsigned LVL_W = $clog2(`FSYNC_AGGR_W);  // Level is an index into aggr.

  typedef logic [`FSYNC_ID_W-1:0] fsync_id_t;
  typedef logic [LVL_W-1:0]       fsync_lvl_t;

  // Request arriving on an RX port.
  typedef struct packed {
    logic                     sync;
    logic [`FSYNC_AGGR_W-1:0] aggr;
    fsync_id_t                id;
  } fsync_req_in_t;

  // Request sent one level up, aggregate already shifted.
  typedef struct packed {
    logic                     sync;
    logic [`FSYNC_AGGR_W-2:0] aggr;
    fsync_id_t                id;
  } fsync_req_out_t;

  // Wake response towards the local side.
  typedef struct packed {
    logic       wake;
    fsync_lvl_t lvl;
    fsync_id_t  id;
    logic       error;
  } fsync_rsp_t;

  // Back-route direction, en in bit 0.
  typedef struct packed {
    logic ws;
    logic en;
  } fsync_sd_t;

  localparam fsync_sd_t SD_EAST_NORTH = 2'b01;  // Arrived on RX port 0.
  localparam fsync_sd_t SD_WEST_SOUTH = 2'b10;  // Arrived on RX port 1.

endpackage

`default_nettype wire

/* fsync_defs.svh */
// Size macros of the synchronization control core, included by the RTL and the testbench.
`ifndef FSYNC_DEFS_SVH
`define FSYNC_DEFS_SVH

// Width of the barrier id field.
`define FSYNC_ID_W 3

// Width of the incoming aggregate field.
`define FSYNC_AGGR_W 4

// Entries in the local and remote tables.
// Ids at or above this value are out of range.
`define FSYNC_N_REGS 6

// Entries in each response and request FIFO.
`define FSYNC_FIFO_DEPTH 2

// Number of RX ports of the horizontal node.
`define FSYNC_N_RX 2

`endif
